// ==== src/lander_pkg.sv ====
/*
  shared types for the lander cabinet control path
  pad, lamp, overlay and cabinet frame structs
  difficulty, overlay state and bus op enums, bus constants
*/
`default_nettype none

package lander_pkg;

  // host bus data and address width
  localparam int BUS_W = 32;

  // top of the thrust ramp
  localparam logic [7:0] THRUST_MAX = 8'd254;

  // zoom setting register address
  localparam logic [BUS_W-1:0] ZOOM_ADDR = 32'h5000_0000;

  //////////////////////////////
  // pad key bitmap, bit 0 = dpad up
  typedef struct packed {
    logic face_start;
    logic face_select;
    logic trig_r3;
    logic trig_l3;
    logic trig_r2;
    logic trig_l2;
    logic trig_r1;
    logic trig_l1;
    logic face_y;
    logic face_x;
    logic face_b;
    logic face_a;
    logic dpad_right;
    logic dpad_left;
    logic dpad_down;
    logic dpad_up;
  } pad_t;

  // lamps from the game
  typedef struct packed {
    logic lamp5;
    logic lamp4;
    logic lamp3;
  } lamp_t;

  typedef enum logic [1:0] {DIFF_0, DIFF_1, DIFF_2, DIFF_3} difficulty_e;

  typedef struct packed {
    logic        en;
    difficulty_e diff;
  } overlay_t;

  //////////////////////////////
  // cabinet word, buttons active low
  typedef struct packed {
    logic        turn_l_n;
    logic        turn_r_n;
    logic        abort_n;
    logic        select_n;
    logic        start_n;
    logic        coin_n;
    logic [7:0]  thrust;
    overlay_t    overlay;
    logic [1:0]  zoom;
  } cab_ctrl_t;

  typedef enum logic {OVL_IDLE, OVL_SHOW} ovl_state_e;

  // decoded host strobe pair
  typedef enum logic [1:0] {BUS_IDLE, BUS_WRITE, BUS_READ} bus_op_e;

endpackage

`default_nettype wire

// ==== src/thrust_ramp.sv ====
/*
  thrust ramp
  free-running step tick counter
  saturating 8-bit thrust driven by face a / face b
*/
`timescale 1ns/100ps
`default_nettype none

module thrust_ramp import lander_pkg::*; #(
  parameter int THRUST_TICK = 196850
) (
  input  wire        clk_50,
  input  wire        i_rst_n,
  input  pad_t       i_pad1,
  input  pad_t       i_pad2,
  output logic [7:0] o_thrust
);

  // counter just wide enough for one tick period
  localparam int CNT_W = (THRUST_TICK > 1) ? $clog2(THRUST_TICK) : 1;
  localparam logic [CNT_W-1:0] TICK_LAST = CNT_W'(THRUST_TICK - 1);

  logic [CNT_W-1:0] tick_cnt;
  logic             tick_wrap;
  logic             raise_req;
  logic             lower_req;

  //////////////////////////////
  // step tick

  assign tick_wrap = (tick_cnt == TICK_LAST);

  always_ff @(posedge clk_50) begin
    if (!i_rst_n) begin
      tick_cnt <= '0;
    end else if (tick_wrap) begin
      tick_cnt <= '0;
    end else begin
      tick_cnt <= tick_cnt + 1'b1;
    end
  end

  //////////////////////////////
  // ramp

  // either pad may drive the throttle
  assign raise_req = i_pad1.face_a | i_pad2.face_a;
  assign lower_req = i_pad1.face_b | i_pad2.face_b;

  always_ff @(posedge clk_50) begin
    if (!i_rst_n) begin
      o_thrust <= 8'd0;
    end else if (tick_wrap) begin
      // raise has priority over lower
      if (raise_req) begin
        if (o_thrust < THRUST_MAX)
          o_thrust <= o_thrust + 8'd1;
      end else if (lower_req && o_thrust != 8'd0) begin
        o_thrust <= o_thrust - 8'd1;
      end
    end
  end

  // ramp must stay inside the game's thrust range
  a_thrust_max : assert property (@(posedge clk_50) disable iff (!i_rst_n)
    o_thrust <= THRUST_MAX);

endmodule

`default_nettype wire

// ==== src/overlay_timer.sv ====
/*
  difficulty overlay timer
  select-triggered countdown with idle/show state
  lamp priority encoder, registered difficulty
*/
`timescale 1ns/100ps
`default_nettype none

module overlay_timer import lander_pkg::*; #(
  parameter int OVERLAY_CYCLES = 500000000
) (
  input  wire      clk_50,
  input  wire      i_rst_n,
  input  pad_t     i_pad1,
  input  pad_t     i_pad2,
  input  lamp_t    i_lamps,
  output overlay_t o_overlay
);

  localparam int CNT_W = $clog2(OVERLAY_CYCLES + 1);
  localparam logic [CNT_W-1:0] OVL_LOAD = CNT_W'(OVERLAY_CYCLES);

  logic [CNT_W-1:0] ovl_cnt;
  logic [CNT_W-1:0] ovl_cnt_nxt;
  ovl_state_e       ovl_state;
  ovl_state_e       ovl_state_nxt;
  difficulty_e      diff_enc;
  difficulty_e      diff_q;
  logic             sel_held;

  //////////////////////////////
  // countdown

  assign sel_held = i_pad1.face_select | i_pad2.face_select;

  // select reloads, even mid overlay
  always_comb begin
    ovl_cnt_nxt = ovl_cnt;
    if (sel_held)
      ovl_cnt_nxt = OVL_LOAD;
    else if (ovl_cnt != '0)
      ovl_cnt_nxt = ovl_cnt - 1'b1;
  end

  // idle until select, show until the last count
  always_comb begin
    ovl_state_nxt = ovl_state;
    case (ovl_state)
      OVL_IDLE: begin
        if (sel_held)
          ovl_state_nxt = OVL_SHOW;
      end
      OVL_SHOW: begin
        if (!sel_held && ovl_cnt == CNT_W'(1))
          ovl_state_nxt = OVL_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_50) begin
    if (!i_rst_n) begin
      ovl_cnt   <= '0;
      ovl_state <= OVL_IDLE;
    end else begin
      ovl_cnt   <= ovl_cnt_nxt;
      ovl_state <= ovl_state_nxt;
    end
  end

  //////////////////////////////
  // difficulty from lamps, highest lamp wins
  always_comb begin
    if (i_lamps.lamp5)
      diff_enc = DIFF_3;
    else if (i_lamps.lamp4)
      diff_enc = DIFF_2;
    else if (i_lamps.lamp3)
      diff_enc = DIFF_1;
    else
      diff_enc = DIFF_0;
  end

  always_ff @(posedge clk_50) begin
    diff_q <= diff_enc;
  end

  assign o_overlay.en   = (ovl_state == OVL_SHOW);
  assign o_overlay.diff = diff_q;

  a_show_cnt : assert property (@(posedge clk_50) disable iff (!i_rst_n)
    (ovl_state == OVL_SHOW) == (ovl_cnt != '0));

endmodule

`default_nettype wire

// ==== src/settings_regs.sv ====
/*
  host bus settings register
  strobe decode, zoom address match
  zoom register and registered read-back
*/
`timescale 1ns/100ps
`default_nettype none

module settings_regs import lander_pkg::*; (
  input  wire              clk_50,
  input  wire              i_rst_n,
  input  wire              i_bus_wr,
  input  wire              i_bus_rd,
  input  wire  [BUS_W-1:0] i_bus_addr,
  input  wire  [BUS_W-1:0] i_bus_wr_data,
  output logic [BUS_W-1:0] o_bus_rd_data,
  output logic [1:0]       o_zoom
);

  bus_op_e bus_op;
  logic    zoom_hit;

  //////////////////////////////
  // decode

  // single-cycle strobes, never both at once
  always_comb begin
    if (i_bus_wr)
      bus_op = BUS_WRITE;
    else if (i_bus_rd)
      bus_op = BUS_READ;
    else
      bus_op = BUS_IDLE;
  end

  assign zoom_hit = (i_bus_addr == ZOOM_ADDR);

  //////////////////////////////
  // zoom register and read-back
  always_ff @(posedge clk_50) begin
    if (!i_rst_n) begin
      o_zoom        <= 2'd0;
      o_bus_rd_data <= '0;
    end else begin
      case (bus_op)
        BUS_WRITE: begin
          if (zoom_hit)
            o_zoom <= i_bus_wr_data[1:0];
        end
        BUS_READ: begin
          // unmapped addresses read back as zero
          o_bus_rd_data <= zoom_hit ? {{(BUS_W-2){1'b0}}, o_zoom} : '0;
        end
        default: ;
      endcase
    end
  end

  a_one_strobe : assert property (@(posedge clk_50) disable iff (!i_rst_n)
    !(i_bus_wr && i_bus_rd));

endmodule

`default_nettype wire

// ==== src/cabinet_frame.sv ====
/*
  cabinet frame builder
  pad merge into active-low buttons
  registered cabinet word with thrust, overlay, zoom
*/
`timescale 1ns/100ps
`default_nettype none

module cabinet_frame import lander_pkg::*; (
  input  wire        clk_50,
  input  wire        i_rst_n,
  input  pad_t       i_pad1,
  input  pad_t       i_pad2,
  input  wire  [7:0] i_thrust,
  input  overlay_t   i_overlay,
  input  wire  [1:0] i_zoom,
  output cab_ctrl_t  o_cab
);

  cab_ctrl_t cab_nxt;
  pad_t      pad_or;

  //////////////////////////////
  // button merge

  // a key counts if held on either pad
  assign pad_or = i_pad1 | i_pad2;

  always_comb begin
    // cabinet buttons are active low
    cab_nxt.turn_l_n = ~pad_or.dpad_left;
    cab_nxt.turn_r_n = ~pad_or.dpad_right;
    cab_nxt.abort_n  = ~pad_or.trig_l1;
    cab_nxt.select_n = ~pad_or.face_select;
    cab_nxt.start_n  = ~pad_or.face_start;
    // both coin slots share r1
    cab_nxt.coin_n   = ~pad_or.trig_r1;
    // pass-through fields
    cab_nxt.thrust   = i_thrust;
    cab_nxt.overlay  = i_overlay;
    cab_nxt.zoom     = i_zoom;
  end

  //////////////////////////////
  // frame register

  always_ff @(posedge clk_50) begin
    if (!i_rst_n) begin
      // buttons released, everything else idle
      o_cab.turn_l_n   <= 1'b1;
      o_cab.turn_r_n   <= 1'b1;
      o_cab.abort_n    <= 1'b1;
      o_cab.select_n   <= 1'b1;
      o_cab.start_n    <= 1'b1;
      o_cab.coin_n     <= 1'b1;
      o_cab.thrust     <= 8'd0;
      o_cab.overlay.en <= 1'b0;
      o_cab.overlay.diff <= DIFF_0;
      o_cab.zoom       <= 2'd0;
    end else begin
      // whole word moves on one edge
      o_cab <= cab_nxt;
    end
  end

  // overlay can only be raised by a select press
  a_ovl_from_sel : assert property (@(posedge clk_50) disable iff (!i_rst_n)
    $rose(o_cab.overlay.en) |-> $past(!o_cab.select_n, 1) || !o_cab.select_n);

endmodule

`default_nettype wire

// ==== src/lander_ctrl_top.sv ====
/*
  cabinet control path top level
  thrust ramp, overlay timer, settings register, frame builder
*/
`timescale 1ns/100ps
`default_nettype none

module lander_ctrl_top import lander_pkg::*; #(
  parameter int THRUST_TICK    = 196850,
  parameter int OVERLAY_CYCLES = 500000000
) (
  input  wire              clk_50,
  input  wire              i_rst_n,
  input  pad_t             i_pad1,
  input  pad_t             i_pad2,
  input  lamp_t            i_lamps,
  input  wire              i_bus_wr,
  input  wire              i_bus_rd,
  input  wire  [BUS_W-1:0] i_bus_addr,
  input  wire  [BUS_W-1:0] i_bus_wr_data,
  output logic [BUS_W-1:0] o_bus_rd_data,
  output cab_ctrl_t        o_cab
);

  logic [7:0] thrust;
  overlay_t   overlay;
  logic [1:0] zoom;

  //////////////////////////////
  // side-by-side producers

  thrust_ramp #(
    .THRUST_TICK (THRUST_TICK)
  ) u_thrust_ramp (
    .clk_50   (clk_50),
    .i_rst_n  (i_rst_n),
    .i_pad1   (i_pad1),
    .i_pad2   (i_pad2),
    .o_thrust (thrust)
  );

  overlay_timer #(
    .OVERLAY_CYCLES (OVERLAY_CYCLES)
  ) u_overlay_timer (
    .clk_50    (clk_50),
    .i_rst_n   (i_rst_n),
    .i_pad1    (i_pad1),
    .i_pad2    (i_pad2),
    .i_lamps   (i_lamps),
    .o_overlay (overlay)
  );

  // host side zoom setting
  settings_regs u_settings_regs (
    .clk_50        (clk_50),
    .i_rst_n       (i_rst_n),
    .i_bus_wr      (i_bus_wr),
    .i_bus_rd      (i_bus_rd),
    .i_bus_addr    (i_bus_addr),
    .i_bus_wr_data (i_bus_wr_data),
    .o_bus_rd_data (o_bus_rd_data),
    .o_zoom        (zoom)
  );

  //////////////////////////////
  // frame builder
  cabinet_frame u_cabinet_frame (
    .clk_50    (clk_50),
    .i_rst_n   (i_rst_n),
    .i_pad1    (i_pad1),
    .i_pad2    (i_pad2),
    .i_thrust  (thrust),
    .i_overlay (overlay),
    .i_zoom    (zoom),
    .o_cab     (o_cab)
  );

endmodule

`default_nettype wire

// ==== verif/lander_checker.sv ====
/*
  checking module for the lander cabinet control path
  reference model of thrust, overlay, zoom and read data
  per-cycle compare and per-test reporting
*/
`timescale 1ns/100ps
`default_nettype none

module lander_checker import lander_pkg::*; #(
  parameter int THRUST_TICK    = 4,
  parameter int OVERLAY_CYCLES = 50
) (
  input  wire              clk_50,
  input  wire              i_rst_n,
  input  pad_t             i_pad1,
  input  pad_t             i_pad2,
  input  lamp_t            i_lamps,
  input  wire              i_bus_wr,
  input  wire              i_bus_rd,
  input  wire  [BUS_W-1:0] i_bus_addr,
  input  wire  [BUS_W-1:0] i_bus_wr_data,
  input  wire  [BUS_W-1:0] i_bus_rd_data,
  input  cab_ctrl_t        i_cab,
  input  int               i_test_id,
  input  wire              i_test_done,
  output int               o_err_count,
  output int               o_check_count,
  output int               o_tests_done
);

  int               cyc;
  int               ovl_cnt_m;
  logic [7:0]       thr_m;
  difficulty_e      diff_m;
  logic [1:0]       zoom_m;
  logic [BUS_W-1:0] rd_m;
  cab_ctrl_t        exp_cab;
  ovl_state_e       exp_state;
  logic             model_valid;
  int               test_errs;

  // highest lit lamp sets the difficulty
  function automatic difficulty_e lamp_priority(lamp_t l);
    if (l.lamp5) return DIFF_3;
    if (l.lamp4) return DIFF_2;
    if (l.lamp3) return DIFF_1;
    return DIFF_0;
  endfunction

  // expected frame, buttons are the inverted OR of both pads
  function automatic cab_ctrl_t expected_frame(pad_t p1, pad_t p2, logic [7:0] thr,
                                               logic en, difficulty_e diff, logic [1:0] zm);
    cab_ctrl_t f;
    f.turn_l_n     = !(p1.dpad_left || p2.dpad_left);
    f.turn_r_n     = !(p1.dpad_right || p2.dpad_right);
    f.abort_n      = !(p1.trig_l1 || p2.trig_l1);
    f.select_n     = !(p1.face_select || p2.face_select);
    f.start_n      = !(p1.face_start || p2.face_start);
    f.coin_n       = !(p1.trig_r1 || p2.trig_r1);
    f.thrust       = thr;
    f.overlay.en   = en;
    f.overlay.diff = diff;
    f.zoom         = zm;
    return f;
  endfunction

  task automatic check_value(string name, logic [BUS_W-1:0] exp, logic [BUS_W-1:0] act);
    o_check_count++;
    if (exp !== act) begin
      o_err_count++;
      test_errs++;
      $display("Error at time %0t: %s expected %0h got %0h", $time, name, exp, act);
    end
  endtask

  initial begin
    model_valid   = 1'b0;
    o_err_count   = 0;
    o_check_count = 0;
    o_tests_done  = 0;
    test_errs     = 0;
  end

  //////////////////////////////
  // model, steps on the same edge as the DUT
  always @(posedge clk_50) begin
    model_valid = 1'b1;
    if (!i_rst_n) begin
      exp_cab   = expected_frame('0, '0, 8'd0, 1'b0, DIFF_0, 2'd0);
      cyc       = 0;
      thr_m     = 8'd0;
      ovl_cnt_m = 0;
      zoom_m    = 2'd0;
      rd_m      = '0;
    end else begin
      // frame takes the values from before this edge
      exp_cab = expected_frame(i_pad1, i_pad2, thr_m, ovl_cnt_m != 0, diff_m, zoom_m);
      // wrap cycle closes every THRUST_TICK cycles, raise beats lower
      if (cyc % THRUST_TICK == THRUST_TICK - 1) begin
        if (i_pad1.face_a || i_pad2.face_a)
          thr_m = (thr_m == THRUST_MAX) ? thr_m : thr_m + 8'd1;
        else if (i_pad1.face_b || i_pad2.face_b)
          thr_m = (thr_m == 8'd0) ? thr_m : thr_m - 8'd1;
      end
      cyc++;
      if (i_pad1.face_select || i_pad2.face_select)
        ovl_cnt_m = OVERLAY_CYCLES;
      else if (ovl_cnt_m > 0)
        ovl_cnt_m--;
      // read returns zoom from before a same-edge write
      if (i_bus_rd)
        rd_m = (i_bus_addr == ZOOM_ADDR) ? {{(BUS_W-2){1'b0}}, zoom_m} : '0;
      if (i_bus_wr && i_bus_addr == ZOOM_ADDR)
        zoom_m = i_bus_wr_data[1:0];
    end
    // difficulty register has no reset
    diff_m = lamp_priority(i_lamps);
    if (i_test_done) begin
      $display("test %0d done: %0d errors", i_test_id, test_errs);
      o_tests_done++;
      test_errs = 0;
    end
  end

  //////////////////////////////
  // compare on the falling edge, outputs settled
  always @(negedge clk_50) begin
    if (model_valid) begin
      exp_state = exp_cab.overlay.en ? OVL_SHOW : OVL_IDLE;
      check_value("o_cab buttons",
                  BUS_W'({exp_cab.turn_l_n, exp_cab.turn_r_n, exp_cab.abort_n,
                          exp_cab.select_n, exp_cab.start_n, exp_cab.coin_n}),
                  BUS_W'({i_cab.turn_l_n, i_cab.turn_r_n, i_cab.abort_n,
                          i_cab.select_n, i_cab.start_n, i_cab.coin_n}));
      check_value("o_cab.thrust", BUS_W'(exp_cab.thrust), BUS_W'(i_cab.thrust));
      check_value($sformatf("o_cab.overlay.en (model %s)", exp_state.name()),
                  BUS_W'(exp_cab.overlay.en), BUS_W'(i_cab.overlay.en));
      check_value("o_cab.overlay.diff", BUS_W'(exp_cab.overlay.diff), BUS_W'(i_cab.overlay.diff));
      check_value("o_cab.zoom", BUS_W'(exp_cab.zoom), BUS_W'(i_cab.zoom));
      check_value("o_bus_rd_data", rd_m, i_bus_rd_data);
    end
  end

endmodule

`default_nettype wire

// ==== verif/tb_lander_ctrl.sv ====
/*
  testbench top for the lander cabinet control path
  clock, reset, xorshift pad stimulus, test sequence
  cycle-count timeout and final verdict
*/
`timescale 1ns/100ps
`default_nettype none

module tb_lander_ctrl import lander_pkg::*; ();

  localparam int TICK       = 4;
  localparam int OVL_LEN    = 50;
  localparam int RST_CYCLES = 16;

  // phase lengths in cycles
  localparam int LEN_RESET  = 40;
  localparam int LEN_RANDOM = 200;
  localparam int LEN_RAISE  = 1100;
  localparam int LEN_LOWER  = 1100;
  localparam int LEN_BOTH   = 100;
  localparam int LEN_OVL    = 300;
  localparam int LEN_BUS    = 100;
  localparam int CYCLE_LIMIT = RST_CYCLES + LEN_RESET + LEN_RANDOM + LEN_RAISE
                             + LEN_LOWER + LEN_BOTH + LEN_OVL + LEN_BUS + 200;

  logic             clk_50;
  logic             rst_n;
  pad_t             pad1;
  pad_t             pad2;
  lamp_t            lamps;
  logic             bus_wr;
  logic             bus_rd;
  logic [BUS_W-1:0] bus_addr;
  logic [BUS_W-1:0] bus_wr_data;
  logic [BUS_W-1:0] bus_rd_data;
  cab_ctrl_t        cab;
  int               test_id;
  logic             test_done;
  int               err_count;
  int               check_count;
  int               tests_done;
  int               cyc_cnt;
  logic [31:0]      rng_state;

  //////////////////////////////
  // clock, 40 ns period
  always #20 clk_50 = ~clk_50;

  lander_ctrl_top #(
    .THRUST_TICK    (TICK),
    .OVERLAY_CYCLES (OVL_LEN)
  ) i_dut (
    .clk_50        (clk_50),
    .i_rst_n       (rst_n),
    .i_pad1        (pad1),
    .i_pad2        (pad2),
    .i_lamps       (lamps),
    .i_bus_wr      (bus_wr),
    .i_bus_rd      (bus_rd),
    .i_bus_addr    (bus_addr),
    .i_bus_wr_data (bus_wr_data),
    .o_bus_rd_data (bus_rd_data),
    .o_cab         (cab)
  );

  // watches every DUT port
  lander_checker #(
    .THRUST_TICK    (TICK),
    .OVERLAY_CYCLES (OVL_LEN)
  ) u_checker (
    .clk_50          (clk_50),
    .i_rst_n         (rst_n),
    .i_pad1          (pad1),
    .i_pad2          (pad2),
    .i_lamps         (lamps),
    .i_bus_wr        (bus_wr),
    .i_bus_rd        (bus_rd),
    .i_bus_addr      (bus_addr),
    .i_bus_wr_data   (bus_wr_data),
    .i_bus_rd_data   (bus_rd_data),
    .i_cab           (cab),
    .i_test_id       (test_id),
    .i_test_done     (test_done),
    .o_err_count     (err_count),
    .o_check_count   (check_count),
    .o_tests_done    (tests_done)
  );

  // 32-bit xorshift step
  function automatic logic [31:0] xorshift32(logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // drive point, 2 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk_50);
    #2;
  endtask

  task automatic run_cycles(int n);
    repeat (n) next_cycle();
  endtask

  // one-cycle done pulse, checker reports on it
  task automatic end_test();
    test_done = 1'b1;
    next_cycle();
    test_done = 1'b0;
  endtask

  // single-cycle strobe then one idle cycle
  task automatic bus_access(bus_op_e op, logic [BUS_W-1:0] addr, logic [BUS_W-1:0] data);
    bus_addr    = addr;
    bus_wr_data = data;
    bus_wr      = (op == BUS_WRITE);
    bus_rd      = (op == BUS_READ);
    next_cycle();
    bus_wr = 1'b0;
    bus_rd = 1'b0;
    next_cycle();
  endtask

  //////////////////////////////
  // timeout
  always @(posedge clk_50) begin
    cyc_cnt = cyc_cnt + 1;
    if (cyc_cnt == CYCLE_LIMIT) begin
      $display("timeout: the test sequence did not finish within %0d cycles", CYCLE_LIMIT);
      $display("TEST FAILED");
      $finish;
    end
  end

  //////////////////////////////
  // test sequence
  initial begin
    clk_50      = 1'b0;
    rst_n       = 1'b0;
    pad1        = '0;
    pad2        = '0;
    lamps       = '0;
    bus_wr      = 1'b0;
    bus_rd      = 1'b0;
    bus_addr    = '0;
    bus_wr_data = '0;
    test_id     = 1;
    test_done   = 1'b0;
    cyc_cnt     = 0;
    rng_state   = 32'd47;
    repeat (RST_CYCLES) @(posedge clk_50);
    #2;
    rst_n = 1'b1;

    // 1: reset values, idle then read zoom
    run_cycles(LEN_RESET - 4);
    bus_access(BUS_READ, ZOOM_ADDR, '0);
    end_test();

    // 2: random pads for button mapping
    test_id = 2;
    repeat (LEN_RANDOM) begin
      rng_state = xorshift32(rng_state);
      pad1 = pad_t'(rng_state[15:0]);
      pad2 = pad_t'(rng_state[31:16]);
      next_cycle();
    end
    pad1 = '0;
    pad2 = '0;
    end_test();

    // 3: ramp up to the top, down to zero, then both held
    test_id = 3;
    pad1.face_a = 1'b1;
    run_cycles(LEN_RAISE);
    pad1 = '0;
    pad2.face_b = 1'b1;
    run_cycles(LEN_LOWER);
    pad1.face_a = 1'b1;
    run_cycles(LEN_BOTH);
    pad1 = '0;
    pad2 = '0;
    end_test();

    // 4: single press, restart mid overlay, lamp priority
    test_id = 4;
    run_cycles(OVL_LEN + 10);
    pad2.face_select = 1'b1;
    next_cycle();
    pad2 = '0;
    run_cycles(30);
    pad1.face_select = 1'b1;
    next_cycle();
    pad1 = '0;
    run_cycles(OVL_LEN + 10);
    for (int i = 0; i < 8; i++) begin
      lamps = lamp_t'(i[2:0]);
      run_cycles(4);
    end
    lamps = '0;
    end_test();

    // 5: zoom write, read-back, unmapped accesses
    test_id = 5;
    bus_access(BUS_WRITE, ZOOM_ADDR, 32'h0000_0003);
    bus_access(BUS_READ, ZOOM_ADDR, '0);
    bus_access(BUS_READ, ZOOM_ADDR + 32'h4, '0);
    bus_access(BUS_WRITE, 32'h5000_0010, 32'h0000_0001);
    bus_access(BUS_READ, ZOOM_ADDR, '0);
    bus_access(BUS_WRITE, ZOOM_ADDR, 32'hFFFF_FFFE);
    bus_access(BUS_READ, ZOOM_ADDR, '0);
    run_cycles(4);
    end_test();

    next_cycle();
    $display("summary: %0d tests, %0d checks, %0d errors", tests_done, check_count, err_count);
    if (err_count == 0 && tests_done == 5) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== list.f ====
src/lander_pkg.sv
src/thrust_ramp.sv
src/overlay_timer.sv
src/settings_regs.sv
src/cabinet_frame.sv
src/lander_ctrl_top.sv
verif/lander_checker.sv
verif/tb_lander_ctrl.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the lander cabinet control testbench with Verilator and run it
set -euo pipefail

cd "$(dirname "$0")"

top=tb_lander_ctrl
obj=obj_dir
log=sim.log

# compile with assertions and timing support
verilator --binary --timing --assert -Wno-fatal \
  --timescale 1ns/100ps \
  --top-module "$top" --Mdir "$obj" \
  -f list.f

# run and keep a log
"./$obj/V$top" | tee "$log"

# verdict comes from the log
if grep -q "TEST FAILED" "$log"; then
  echo "simulation reported a failure, see $log"
  exit 1
fi

echo "simulation finished without failure, log in $log"
exit 0
